//--- filelist.f
src/pagPkg.sv
src/pagTableMem.sv
src/pagSweepCounter.sv
src/pagCtrl.sv
src/pagApbRegs.sv
src/pagAccessCheck.sv
src/pagTop.sv
verification/pagTb.sv

//--- verification/pagTb.sv
`timescale 1ns/1ns
`default_nettype none
module pagTb import pagPkg::*; ();

  localparam int apbTimeout = 100;
  localparam int readyTimeout = 100;
  localparam int drainTimeout = 10;
  localparam int numPages = 12;

  logic clk = 1'b0;
  logic arstN;
  apbReqT apbReq;
  apbRspT apbRsp;
  logic reqValid;
  xlateReqT req;
  logic reqReady;
  logic rspValid;
  xlateRspT rsp;

  // Shadow of the entry table and directory
  ptLineT shLine [numLines];
  ptDirT shDir [numLines];
  logic [2:0] ctrlShadow;
  xlateReqT pages [$];
  xlateRspT expQ [$];
  int acceptCycle [$];
  xlateRspT expRsp;
  pfCodeT lastExpCode;
  int cycle;
  int latency;
  int checks;
  int errors;
  int testChecks;
  int testErrors;
  int seedVal;
  logic [31:0] rdData;
  logic rdErr;
  int waited;
  xlateReqT page;
  xlateReqT other;
  ptHalfT half;

  always #5 clk = ~clk;

  pagTop u_pagTop (
    .clk, .arstN, .apbReq, .apbRsp, .reqValid, .req, .reqReady, .rspValid, .rsp
  );

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic finishTest(input string name);
    $display("Test %s: %0d checks, %0d errors", name, checks - testChecks,
             errors - testErrors);
    testChecks = checks;
    testErrors = errors;
  endtask

  // Setup phase, then access phase held until pready
  task automatic apbTransfer(input logic write, input logic [3:0] addr,
                             input logic [31:0] data);
    @(posedge clk);
    apbReq.psel <= 1'b1;
    apbReq.penable <= 1'b0;
    apbReq.pwrite <= write;
    apbReq.paddr <= addr;
    apbReq.pwdata <= data;
    @(posedge clk);
    apbReq.penable <= 1'b1;
    @(negedge clk);
    waited = 0;
    while (apbRsp.pready !== 1'b1 && waited < apbTimeout) begin
      @(negedge clk);
      waited++;
    end
    if (apbRsp.pready !== 1'b1) begin
      errors++;
      $display("APB access to offset %h timed out waiting for pready", addr);
    end
    rdData = apbRsp.prdata;
    rdErr = apbRsp.pslverr;
    @(posedge clk);
    apbReq.psel <= 1'b0;
    apbReq.penable <= 1'b0;
  endtask

  function automatic void clearDir();
    for (int i = 0; i < numLines; i++) begin
      shDir[i] = '0;
    end
  endfunction

  task automatic setCtrl(input logic [2:0] value);
    apbTransfer(1'b1, ctrlReg, {29'b0, value});
    ctrlShadow = value;
    if (value[0]) begin
      clearDir();
    end
  endtask

  function automatic void shadowCommit(input xlateReqT p, input ptHalfT h);
    logic [lineW-1:0] ln;
    logic [tagW-1:0] tag;
    logic par;
    logic keep;
    ln = p.vpn[6:1];
    tag = {p.user, p.vpn[11:7]};
    // Odd parity over the half and its parity bit
    par = ~(^h) ^ ctrlShadow[2];
    keep = shDir[ln].tag == tag;
    if (p.vpn[0]) begin
      shLine[ln].odd = h;
      shLine[ln].oddPar = par;
      shDir[ln].oddValid = 1'b1;
      shDir[ln].evenValid = shDir[ln].evenValid & keep;
    end else begin
      shLine[ln].even = h;
      shLine[ln].evenPar = par;
      shDir[ln].evenValid = 1'b1;
      shDir[ln].oddValid = shDir[ln].oddValid & keep;
    end
    shDir[ln].tag = tag;
  endfunction

  task automatic commitPage(input xlateReqT p, input ptHalfT h);
    apbTransfer(1'b1, addrReg, {19'b0, p.user, p.vpn});
    apbTransfer(1'b1, dataReg, {14'b0, h});
    shadowCommit(p, h);
  endtask

  function automatic xlateRspT refXlate(input xlateReqT r, input logic paging);
    xlateRspT e;
    logic [lineW-1:0] ln;
    ptHalfT h;
    logic par;
    logic vld;
    e = '0;
    ln = r.vpn[6:1];
    h = r.vpn[0] ? shLine[ln].odd : shLine[ln].even;
    par = r.vpn[0] ? shLine[ln].oddPar : shLine[ln].evenPar;
    vld = r.vpn[0] ? shDir[ln].oddValid : shDir[ln].evenValid;
    if (!paging) begin
      e.ppn = {1'b0, r.vpn};
    end else if (shDir[ln].tag != {r.user, r.vpn[11:7]} || !vld) begin
      e.pfCode = pfRefill;
    end else if (^{h, par} == 1'b0) begin
      e.pfCode = pfParity;
    end else if (!h.access) begin
      e.pfCode = pfNoAccess;
    end else if (r.publicMode && !h.public) begin
      e.pfCode = pfPrivate;
    end else if (r.write && !h.writable) begin
      e.pfCode = pfWrite;
    end else begin
      e.ppn = h.ppn;
      e.cache = h.cache;
      e.software = h.software;
    end
    e.fail = e.pfCode != pfNone;
    return e;
  endfunction

  function automatic ptHalfT randomHalf();
    logic [31:0] rnd;
    ptHalfT h;
    rnd = $urandom;
    h = rnd[17:0];
    // Mostly accessible so the later checks get exercised
    h.access = rnd[20] | rnd[21];
    return h;
  endfunction

  function automatic xlateReqT randomReq(input logic fromPages);
    logic [31:0] rnd;
    xlateReqT r;
    rnd = $urandom;
    r = rnd[14:0];
    if (fromPages && pages.size() > 0) begin
      r = pages[$urandom % pages.size()];
      r.write = rnd[0];
      r.publicMode = rnd[1];
      if (rnd[3:2] == 2'b00) begin
        r.vpn[0] = ~r.vpn[0];
      end
    end
    return r;
  endfunction

  task automatic sendReq(input xlateReqT r);
    int waitCount;
    @(posedge clk);
    reqValid <= 1'b1;
    req <= r;
    @(negedge clk);
    waitCount = 0;
    while (reqReady !== 1'b1 && waitCount < readyTimeout) begin
      @(negedge clk);
      waitCount++;
    end
    if (reqReady !== 1'b1) begin
      errors++;
      $display("Request timed out waiting for reqReady at %0t", $time);
    end
  endtask

  // Back-to-back requests, then wait for all responses
  task automatic burst(input int count, input logic fromPages);
    int waitCount;
    for (int i = 0; i < count; i++) begin
      sendReq(randomReq(fromPages));
    end
    @(posedge clk);
    reqValid <= 1'b0;
    waitCount = 0;
    while (expQ.size() != 0 && waitCount < drainTimeout) begin
      @(negedge clk);
      waitCount++;
    end
    if (expQ.size() != 0) begin
      errors++;
      $display("%0d responses never arrived", expQ.size());
    end
  endtask

  task automatic waitSweep();
    int polls;
    logic seenBusy;
    polls = 0;
    apbTransfer(1'b0, statusReg, 32'h0);
    seenBusy = rdData[0];
    while (rdData[0] === 1'b1 && polls < numLines) begin
      apbTransfer(1'b0, statusReg, 32'h0);
      polls++;
    end
    if (seenBusy !== 1'b1) begin
      errors++;
      $display("Sweep never showed busy in statusReg");
    end
    if (rdData[0] !== 1'b0) begin
      errors++;
      $display("Sweep did not finish before its timeout");
    end
  endtask

  // Compare each response with the expectation queued at acceptance
  always @(negedge clk) begin
    if (arstN === 1'b1) begin
      cycle++;
      if (reqValid === 1'b1 && reqReady === 1'b1) begin
        expRsp = refXlate(req, ctrlShadow[1]);
        expQ.push_back(expRsp);
        acceptCycle.push_back(cycle);
        lastExpCode = expRsp.pfCode;
      end
      if (rspValid === 1'b1) begin
        if (expQ.size() == 0) begin
          errors++;
          $display("Response at %0t with no request in flight", $time);
        end else begin
          expRsp = expQ.pop_front();
          latency = cycle - acceptCycle.pop_front();
          checkValue("rspLatency", latency, 2);
          checkValue("rsp.pfCode", rsp.pfCode, expRsp.pfCode);
          checkValue("rsp.fail", rsp.fail, expRsp.fail);
          if (!expRsp.fail) begin
            checkValue("rsp.ppn", rsp.ppn, expRsp.ppn);
            checkValue("rsp.cache", rsp.cache, expRsp.cache);
            checkValue("rsp.software", rsp.software, expRsp.software);
          end
        end
      end
    end
  end

  initial begin
    #1000000;
    $display("Simulation time limit reached");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    arstN = 1'b0;
    apbReq = '0;
    reqValid = 1'b0;
    req = '0;
    ctrlShadow = '0;
    lastExpCode = pfNone;
    cycle = 0;
    checks = 0;
    errors = 0;
    testChecks = 0;
    testErrors = 0;
    seedVal = $urandom(32'h6ddba401);
    repeat (4) @(posedge clk);
    @(negedge clk);
    checkValue("apbRsp.pready", apbRsp.pready, 1'b0);
    checkValue("reqReady", reqReady, 1'b0);
    checkValue("rspValid", rspValid, 1'b0);
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    checkValue("apbRsp.pready", apbRsp.pready, 1'b1);

    burst(20, 1'b0);
    finishTest("1 unpaged");

    setCtrl(3'b011);
    waitSweep();
    burst(20, 1'b0);
    finishTest("2 sweep then refill");

    pages.delete();
    for (int i = 0; i < numPages; i++) begin
      page = randomReq(1'b0);
      commitPage(page, randomHalf());
      pages.push_back(page);
    end
    // Other half of a used line under a new tag
    other = pages[0];
    other.vpn[0] = ~other.vpn[0];
    other.vpn[11] = ~other.vpn[11];
    commitPage(other, randomHalf());
    pages.push_back(other);
    other.vpn[0] = ~other.vpn[0];
    pages.push_back(other);
    // Half whose valid bit the new tag cleared
    sendReq(other);
    burst(60, 1'b1);
    finishTest("3 refill and access checks");

    setCtrl(3'b110);
    for (int i = 0; i < 4; i++) begin
      page = randomReq(1'b0);
      commitPage(page, randomHalf());
      pages.push_back(page);
    end
    setCtrl(3'b010);
    burst(40, 1'b1);
    finishTest("4 bad parity");

    setCtrl(3'b011);
    // dataReg write stalls until the sweep ends
    page = randomReq(1'b0);
    half = randomHalf();
    apbTransfer(1'b1, addrReg, {19'b0, page.user, page.vpn});
    apbTransfer(1'b1, dataReg, {14'b0, half});
    checkValue("dataRegStall", waited >= numLines, 1'b1);
    shadowCommit(page, half);
    pages.push_back(page);
    burst(40, 1'b1);
    apbTransfer(1'b0, statusReg, 32'h0);
    checkValue("status.lastCode", rdData[3:1], lastExpCode);
    checkValue("status.busy", rdData[0], 1'b0);
    checkValue("status.pslverr", rdErr, 1'b0);
    apbTransfer(1'b0, addrReg, 32'h0);
    checkValue("addrReg", rdData, {19'b0, page.user, page.vpn});
    apbTransfer(1'b0, dataReg, 32'h0);
    checkValue("dataReg", rdData, {14'b0, half});
    apbTransfer(1'b0, ctrlReg, 32'h0);
    checkValue("ctrlReg", rdData, {29'b0, ctrlShadow[2:1], 1'b0});
    apbTransfer(1'b0, 4'h2, 32'h0);
    checkValue("apbRsp.pslverr", rdErr, 1'b1);
    apbTransfer(1'b1, 4'hE, 32'h5);
    checkValue("apbRsp.pslverr", rdErr, 1'b1);
    finishTest("5 sweep clear and status");

    $display("Totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
`default_nettype wire

//--- src/pagTop.sv
`timescale 1ns/1ns
`default_nettype none
module pagTop import pagPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  apbReqT   apbReq,
  output apbRspT   apbRsp,
  input  logic     reqValid,
  input  xlateReqT req,
  output logic     reqReady,
  output logic     rspValid,
  output xlateRspT rsp
);

  logic commitReq, commitDone, sweepReq, sweepStart;
  logic busy, pagingEn, parityInvert, rdAddrSel;
  logic sweepRun, accept;
  logic [lineW-1:0] sweepLine, rdAddr;
  logic [vpnW:0] target;
  ptHalfT halfData;
  ptLineT rdLine;
  ptDirT rdDir;
  tblWriteT tblWrite;
  pfCodeT lastCode;

  assign accept = reqValid & reqReady;
  // Commit read borrows the port from translations
  assign rdAddr = rdAddrSel ? target[lineW:1] : req.vpn[lineW:1];

  pagApbRegs u_apbRegs (
    .clk, .arstN, .apbReq, .apbRsp, .commitDone, .busy, .lastCode,
    .commitReq, .sweepReq, .target, .halfData, .pagingEn, .parityInvert
  );

  pagCtrl u_ctrl (
    .clk, .arstN, .commitReq, .sweepReq, .halfData, .target, .parityInvert,
    .oldLine(rdLine), .oldDir(rdDir), .sweepRun, .sweepLine, .sweepStart,
    .rdAddrSel, .commitDone, .tblWrite, .reqReady, .busy
  );

  pagSweepCounter u_sweepCounter (
    .clk, .arstN, .start(sweepStart), .run(sweepRun), .line(sweepLine), .last()
  );

  pagTableMem #(.payloadT(ptLineT)) u_entryMem (
    .clk,
    .we(tblWrite.weEntry),
    .waddr(tblWrite.line),
    .wdata(tblWrite.lineData),
    .raddr(rdAddr),
    .rdata(rdLine)
  );

  pagTableMem #(.payloadT(ptDirT)) u_dirMem (
    .clk,
    .we(tblWrite.weDir),
    .waddr(tblWrite.line),
    .wdata(tblWrite.dirData),
    .raddr(rdAddr),
    .rdata(rdDir)
  );

  pagAccessCheck u_accessCheck (
    .clk, .arstN, .accept, .req, .pagingEn, .rdLine, .rdDir,
    .rspValid, .rsp, .lastCode
  );

endmodule
`default_nettype wire

//--- src/pagAccessCheck.sv
`timescale 1ns/1ns
`default_nettype none
module pagAccessCheck import pagPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  logic     accept,
  input  xlateReqT req,
  input  logic     pagingEn,
  input  ptLineT   rdLine,
  input  ptDirT    rdDir,
  output logic     rspValid,
  output xlateRspT rsp,
  output pfCodeT   lastCode
);

  logic s1Valid;
  logic s1Paging;
  xlateReqT s1Req;
  ptHalfT selHalf;
  logic selPar;
  logic selValid;
  logic hit;
  pfCodeT code;
  xlateRspT rspNext;

  // Stage 1 lines up with the registered RAM read
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1Req <= req;
      s1Paging <= pagingEn;
    end
  end

  assign selHalf = s1Req.vpn[0] ? rdLine.odd : rdLine.even;
  assign selPar = s1Req.vpn[0] ? rdLine.oddPar : rdLine.evenPar;
  assign selValid = s1Req.vpn[0] ? rdDir.oddValid : rdDir.evenValid;
  assign hit = selValid && (rdDir.tag == {s1Req.user, s1Req.vpn[vpnW-1:lineW+1]});

  always_comb begin
    if (!s1Paging) begin
      code = pfNone;
    end else if (!hit) begin
      code = pfRefill;
    end else if (!(^{selHalf, selPar})) begin
      code = pfParity;
    end else if (!selHalf.access) begin
      code = pfNoAccess;
    end else if (s1Req.publicMode && !selHalf.public) begin
      code = pfPrivate;
    end else if (s1Req.write && !selHalf.writable) begin
      code = pfWrite;
    end else begin
      code = pfNone;
    end
  end

  always_comb begin
    rspNext = '0;
    rspNext.pfCode = code;
    rspNext.fail = code != pfNone;
    if (!s1Paging) begin
      rspNext.ppn = ppnW'(s1Req.vpn);
    end else if (code == pfNone) begin
      rspNext.ppn = selHalf.ppn;
      rspNext.cache = selHalf.cache;
      rspNext.software = selHalf.software;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rspValid <= 1'b0;
      lastCode <= pfNone;
    end else begin
      rspValid <= s1Valid;
      if (s1Valid) begin
        lastCode <= code;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1Valid) begin
      rsp <= rspNext;
    end
  end

endmodule
`default_nettype wire

//--- src/pagApbRegs.sv
`timescale 1ns/1ns
`default_nettype none
module pagApbRegs import pagPkg::*; (
  input  logic          clk,
  input  logic          arstN,
  input  apbReqT        apbReq,
  output apbRspT        apbRsp,
  input  logic          commitDone,
  input  logic          busy,
  input  pfCodeT        lastCode,
  output logic          commitReq,
  output logic          sweepReq,
  output logic [vpnW:0] target,
  output ptHalfT        halfData,
  output logic          pagingEn,
  output logic          parityInvert
);

  logic alive;
  logic access;
  logic mapped;
  logic dataWrite;
  logic regWrite;
  logic [vpnW:0] addrQ;
  ptHalfT dataQ;

  assign access = apbReq.psel & apbReq.penable;
  assign mapped = apbReq.paddr inside {addrReg, dataReg, ctrlReg, statusReg};
  assign dataWrite = access & apbReq.pwrite & (apbReq.paddr == dataReg);
  assign regWrite = access & apbReq.pwrite & apbRsp.pready;

  // dataReg write holds the bus until the commit lands
  assign apbRsp.pready = alive & ~(dataWrite & ~commitDone);
  assign apbRsp.pslverr = access & ~mapped;

  assign commitReq = dataWrite;
  assign target = addrQ;
  assign halfData = dataQ;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      alive <= 1'b0;
      sweepReq <= 1'b0;
      pagingEn <= 1'b0;
      parityInvert <= 1'b0;
    end else begin
      alive <= 1'b1;
      sweepReq <= 1'b0;
      if (regWrite && apbReq.paddr == ctrlReg) begin
        sweepReq <= apbReq.pwdata[0];
        pagingEn <= apbReq.pwdata[1];
        parityInvert <= apbReq.pwdata[2];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (regWrite && apbReq.paddr == addrReg) begin
      addrQ <= apbReq.pwdata[vpnW:0];
    end
    if (dataWrite) begin
      dataQ <= apbReq.pwdata[$bits(ptHalfT)-1:0];
    end
  end

  always_comb begin
    apbRsp.prdata = '0;
    case (apbReq.paddr)
      addrReg: apbRsp.prdata[vpnW:0] = addrQ;
      dataReg: apbRsp.prdata[$bits(ptHalfT)-1:0] = dataQ;
      ctrlReg: apbRsp.prdata[2:0] = {parityInvert, pagingEn, sweepReq};
      // Busy in bit 0, fail code above it
      statusReg: apbRsp.prdata[3:0] = {lastCode, busy};
      default: apbRsp.prdata = '0;
    endcase
  end

endmodule
`default_nettype wire

//--- src/pagCtrl.sv
`timescale 1ns/1ns
`default_nettype none
module pagCtrl import pagPkg::*; (
  input  logic             clk,
  input  logic             arstN,
  input  logic             commitReq,
  input  logic             sweepReq,
  input  ptHalfT           halfData,
  input  logic [vpnW:0]    target,
  input  logic             parityInvert,
  input  ptLineT           oldLine,
  input  ptDirT            oldDir,
  input  logic             sweepRun,
  input  logic [lineW-1:0] sweepLine,
  output logic             sweepStart,
  output logic             rdAddrSel,
  output logic             commitDone,
  output tblWriteT         tblWrite,
  output logic             reqReady,
  output logic             busy
);

  typedef enum logic [2:0] {
    stReset,
    stIdle,
    stCommitRead,
    stCommitMerge,
    stCommitWrite,
    stSweep
  } stateT;

  stateT state, stateNext;
  ptLineT mergedLine, wrLine;
  ptDirT mergedDir, wrDir;
  logic [tagW-1:0] newTag;
  logic newPar;
  logic tagHit;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stReset;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    unique case (state)
      stReset: stateNext = stIdle;
      stIdle: begin
        if (sweepReq) begin
          stateNext = stSweep;
        end else if (commitReq) begin
          stateNext = stCommitRead;
        end
      end
      stCommitRead: stateNext = stCommitMerge;
      stCommitMerge: stateNext = stCommitWrite;
      stCommitWrite: stateNext = stIdle;
      stSweep: begin
        if (!sweepRun) begin
          stateNext = stIdle;
        end
      end
      default: stateNext = stReset;
    endcase
  end

  // Tag is the user bit plus the upper vpn bits
  assign newTag = {target[vpnW], target[vpnW-1:lineW+1]};
  assign newPar = ~(^halfData) ^ parityInvert;
  assign tagHit = oldDir.tag == newTag;

  always_comb begin
    mergedLine = oldLine;
    mergedDir.tag = newTag;
    if (target[0]) begin
      mergedLine.odd = halfData;
      mergedLine.oddPar = newPar;
      mergedDir.oddValid = 1'b1;
      mergedDir.evenValid = tagHit & oldDir.evenValid;
    end else begin
      mergedLine.even = halfData;
      mergedLine.evenPar = newPar;
      mergedDir.evenValid = 1'b1;
      mergedDir.oddValid = tagHit & oldDir.oddValid;
    end
  end

  always_ff @(posedge clk) begin
    if (state == stCommitMerge) begin
      wrLine <= mergedLine;
      wrDir <= mergedDir;
    end
  end

  always_comb begin
    tblWrite.line = target[lineW:1];
    tblWrite.weEntry = 1'b0;
    tblWrite.weDir = 1'b0;
    tblWrite.lineData = wrLine;
    tblWrite.dirData = wrDir;
    if (state == stCommitWrite) begin
      tblWrite.weEntry = 1'b1;
      tblWrite.weDir = 1'b1;
    end else if (state == stSweep) begin
      tblWrite.line = sweepLine;
      tblWrite.weDir = sweepRun;
      tblWrite.dirData = '0;
    end
  end

  assign sweepStart = (state == stIdle) && sweepReq;
  assign rdAddrSel = state == stCommitRead;
  assign commitDone = state == stCommitWrite;
  assign reqReady = state == stIdle;
  assign busy = (state == stSweep && sweepRun) || state inside {stCommitRead,
                                                                stCommitMerge,
                                                                stCommitWrite};

endmodule
`default_nettype wire

//--- src/pagSweepCounter.sv
`timescale 1ns/1ns
`default_nettype none
module pagSweepCounter import pagPkg::*; (
  input  logic             clk,
  input  logic             arstN,
  input  logic             start,
  output logic             run,
  output logic [lineW-1:0] line,
  output logic             last
);

  assign last = run && (line == lineW'(numLines - 1));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      run <= 1'b0;
      line <= '0;
    end else if (start) begin
      run <= 1'b1;
      line <= '0;
    end else if (run) begin
      if (last) begin
        run <= 1'b0;
      end else begin
        line <= line + 1'b1;
      end
    end
  end

endmodule
`default_nettype wire

//--- src/pagTableMem.sv
`timescale 1ns/1ns
`default_nettype none
module pagTableMem import pagPkg::*; #(
  parameter type payloadT = logic
) (
  input  logic             clk,
  input  logic             we,
  input  logic [lineW-1:0] waddr,
  input  payloadT          wdata,
  input  logic [lineW-1:0] raddr,
  output payloadT          rdata
);

  payloadT mem [numLines];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    // Old data on a same-line collision
    rdata <= mem[raddr];
  end

endmodule
`default_nettype wire

//--- src/pagPkg.sv
`default_nettype none
package pagPkg;

  localparam int vpnW = 12;
  localparam int ppnW = 13;
  localparam int lineW = 6;
  localparam int numLines = 64;
  localparam int tagW = 6;

  // APB register offsets
  localparam logic [3:0] addrReg = 4'h0;
  localparam logic [3:0] dataReg = 4'h4;
  localparam logic [3:0] ctrlReg = 4'h8;
  localparam logic [3:0] statusReg = 4'hC;

  typedef enum logic [2:0] {
    pfNone,
    pfRefill,
    pfParity,
    pfNoAccess,
    pfPrivate,
    pfWrite
  } pfCodeT;

  // One page half, 18 bits
  typedef struct packed {
    logic access;
    logic public;
    logic writable;
    logic software;
    logic cache;
    logic [ppnW-1:0] ppn;
  } ptHalfT;

  typedef struct packed {
    ptHalfT even;
    logic evenPar;
    ptHalfT odd;
    logic oddPar;
  } ptLineT;

  typedef struct packed {
    logic [tagW-1:0] tag;
    logic evenValid;
    logic oddValid;
  } ptDirT;

  typedef struct packed {
    logic [vpnW-1:0] vpn;
    logic user;
    logic write;
    logic publicMode;
  } xlateReqT;

  typedef struct packed {
    logic [ppnW-1:0] ppn;
    logic fail;
    pfCodeT pfCode;
    logic cache;
    logic software;
  } xlateRspT;

  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    logic [3:0] paddr;
    logic [31:0] pwdata;
  } apbReqT;

  typedef struct packed {
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
  } apbRspT;

  typedef struct packed {
    logic [lineW-1:0] line;
    logic weEntry;
    logic weDir;
    ptLineT lineData;
    ptDirT dirData;
  } tblWriteT;

endpackage
`default_nettype wire
